//--- all.f
+incdir+include
rtl/trace_pkg.sv
rtl/pipe_stage_tracker.sv
rtl/stall_event_logger.sv
rtl/rec_fifo.sv
rtl/trace_arbiter.sv
rtl/trace_apb_regs.sv
rtl/pipe_trace_top.sv
verif/pipe_trace_assertions.sv
verif/pipe_trace_tb.sv

//--- Makefile
TOP := pipe_trace_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -f all.f \
		--top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ) sim.log

//--- verif/pipe_trace_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module pipe_trace_tb
    import trace_pkg::*;
();

    localparam int CLK_NS       = 20;
    localparam int PHASE_CYCLES = 600;
    localparam int WATCHDOG_NS  = (4 * PHASE_CYCLES + 200) * CLK_NS;

    logic                      clk;
    logic                      rst;
    logic                      fetch_valid;
    logic [`TRACE_TAG_W-1:0]   fetch_tag;
    logic                      pc_stall;
    logic                      if_id_stall;
    logic                      if_flush;
    logic                      fetch_ready;
    apb_req_t                  apb_req;
    apb_rsp_t                  apb_rsp;
    logic [31:0]               lfsr;
    logic [`TRACE_TAG_W-1:0]   next_tag;
    int                        errors;
    int                        checks;
    int                        afails;

    // Reference model state
    logic [`TRACE_CYCLE_W-1:0] mc;
    logic                      if_v;
    logic                      id_v;
    retire_rec_t               if_s;
    retire_rec_t               id_s;
    retire_rec_t               ret;
    logic                      adv_if;
    logic                      took;
    logic                      run_open;
    logic [`TRACE_CYCLE_W-1:0] run_start;
    logic [`TRACE_CYCLE_W-1:0] run_len;
    stall_kind_t               run_kind;
    stall_kind_t               cur_kind;
    stall_rec_t                srec;
    retire_rec_t               rq [$];
    stall_rec_t                sq [$];

    pipe_trace_top dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_tag   (fetch_tag),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush),
        .apb_req     (apb_req),
        .fetch_ready (fetch_ready),
        .apb_rsp     (apb_rsp)
    );

    bind pipe_stage_tracker pipe_trace_assertions trk_checks (
        .clk(clk), .rst(rst), .pc_stall(pc_stall), .if_flush(if_flush),
        .fetch_ready(fetch_ready), .rec_push(rec_push),
        .lat(rec.retire_cycle - rec.fetch_cycle), .held(rec.held));

    bind pipe_trace_top pipe_trace_assertions top_checks (
        .clk(clk), .rst(rst), .pc_stall(pc_stall), .if_flush(if_flush),
        .fetch_ready(fetch_ready), .rec_push(ret_pop),
        .lat(ret_dout.retire_cycle - ret_dout.fetch_cycle), .held(ret_dout.held));

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Stage occupancy and stall runs, stepped at each rising edge
    always @(posedge clk) begin
        if (rst) begin
            mc       = '0;
            if_v     = 1'b0;
            id_v     = 1'b0;
            took     = 1'b0;
            run_open = 1'b0;
        end else begin
            adv_if = !pc_stall && (!id_v || !if_id_stall);
            took   = fetch_valid && !pc_stall && !if_flush && (!if_v || adv_if);
            if (if_flush) begin
                if_v = 1'b0;
                id_v = 1'b0;
            end else begin
                if (id_v && !if_id_stall) begin
                    ret              = id_s;
                    ret.retire_cycle = mc + `TRACE_CYCLE_W'(3);
                    rq.push_back(ret);
                end
                if (adv_if) begin
                    id_v = if_v;
                    id_s = if_s;
                end else if (!if_id_stall) begin
                    id_v = 1'b0;
                end else begin
                    id_s.held = id_s.held + `TRACE_HELD_W'(1);
                end
                if (took) begin
                    if_v = 1'b1;
                    if_s = '{tag: fetch_tag, fetch_cycle: mc + `TRACE_CYCLE_W'(1),
                             retire_cycle: '0, held: '0};
                end else if (adv_if) begin
                    if_v = 1'b0;
                end else begin
                    if_s.held = if_s.held + `TRACE_HELD_W'(1);
                end
            end
            cur_kind = '{pc: pc_stall, ifid: if_id_stall, flush: if_flush};
            if (pc_stall || if_id_stall || if_flush) begin
                if (!run_open) begin
                    run_start = mc;
                    run_len   = `TRACE_CYCLE_W'(1);
                    run_kind  = '0;
                end else begin
                    run_len = run_len + `TRACE_CYCLE_W'(1);
                end
                run_kind = run_kind | cur_kind;
                run_open = 1'b1;
            end else if (run_open) begin
                srec             = '0;
                srec.kind        = run_kind;
                srec.start_cycle = run_start;
                srec.length      = run_len;
                sq.push_back(srec);
                run_open = 1'b0;
            end
            mc = mc + `TRACE_CYCLE_W'(1);
        end
    end

    task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [`TRACE_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_NS / 4);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        expect_equal(64'(apb_rsp.pready), 64'd1, "pready in access phase");
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            fetch_valid = 1'b0;
            pc_stall    = 1'b0;
            if_id_stall = 1'b0;
            if_flush    = 1'b0;
        end
    endtask

    // Mode 0 clean stream, 1 random stalls, 2 random stalls and flushes
    task automatic run_stream(input int n, input int mode);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            if (took) begin
                sent++;
                next_tag = next_tag + `TRACE_TAG_W'(1);
            end
            fetch_valid = (sent < n);
            fetch_tag   = next_tag;
            pc_stall    = (mode > 0) && (rand_bits(2) == 32'd3);
            if_id_stall = (mode > 0) && (rand_bits(2) == 32'd3);
            if_flush    = (mode == 2) && (rand_bits(3) == 32'd7);
        end
    endtask

    task automatic clear_and_verify();
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, `TRACE_ADDR_STATUS, 32'd0, rd, err);
        expect_equal(64'(err), 64'd0, "STATUS write error");
        apb_xfer(1'b0, `TRACE_ADDR_STATUS, 32'd0, rd, err);
        expect_equal(64'(rd), 64'd0, "STATUS after clear");
        apb_xfer(1'b0, `TRACE_ADDR_DROPS, 32'd0, rd, err);
        expect_equal(64'(rd), 64'd0, "DROPS after clear");
        rq.delete();
        sq.delete();
    endtask

    task automatic check_log();
        int          n_exp;
        int          n_got;
        int          polls;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] st;
        logic        err;
        retire_rec_t r;
        retire_rec_t exp_r;
        stall_rec_t  s;
        idle(20);
        n_exp = rq.size() + sq.size();
        polls = 0;
        apb_xfer(1'b0, `TRACE_ADDR_STATUS, 32'd0, st, err);
        while (int'(st[5:0]) != n_exp && polls < 100) begin
            apb_xfer(1'b0, `TRACE_ADDR_STATUS, 32'd0, st, err);
            polls++;
        end
        n_got = int'(st[5:0]);
        if (n_got != n_exp) begin
            errors++;
            $display("Log holds %0d entries while %0d were expected", n_got, n_exp);
        end
        for (int i = 0; i < n_got; i++) begin
            apb_xfer(1'b0, `TRACE_ADDR_LOG_BASE + 12'(8 * i), 32'd0, lo, err);
            apb_xfer(1'b0, `TRACE_ADDR_LOG_BASE + 12'(8 * i + 4), 32'd0, hi, err);
            if (!hi[31] && rq.size() > 0) begin
                r     = {hi[15:0], lo};
                exp_r = rq.pop_front();
                expect_equal(64'(r), 64'(exp_r), "retire entry");
                expect_equal(64'(r.retire_cycle - r.fetch_cycle),
                             64'(`TRACE_CYCLE_W'(4) + `TRACE_CYCLE_W'(exp_r.held)),
                             "retire latency");
            end else if (hi[31] && sq.size() > 0) begin
                s = {hi[15:0], lo};
                expect_equal(64'(s), 64'(sq.pop_front()), "stall entry");
            end else begin
                errors++;
                $display("Log entry %0d has no matching expected record", i);
            end
        end
        apb_xfer(1'b0, `TRACE_ADDR_DROPS, 32'd0, st, err);
        expect_equal(64'(st), 64'd0, "DROPS after phase");
        clear_and_verify();
    endtask

    task automatic check_overfill();
        int          exp_drops;
        int          polls;
        logic [31:0] rd;
        logic        err;
        idle(20);
        exp_drops = rq.size() + sq.size() - `TRACE_RAM_DEPTH;
        polls = 0;
        apb_xfer(1'b0, `TRACE_ADDR_DROPS, 32'd0, rd, err);
        while (int'(rd[15:0]) != exp_drops && polls < 100) begin
            apb_xfer(1'b0, `TRACE_ADDR_DROPS, 32'd0, rd, err);
            polls++;
        end
        expect_equal(64'(rd), 64'(exp_drops), "DROPS after overfill");
        apb_xfer(1'b0, `TRACE_ADDR_STATUS, 32'd0, rd, err);
        expect_equal(64'(rd), 64'h8000_0020, "STATUS when full");
        clear_and_verify();
        apb_xfer(1'b0, 12'h00c, 32'd0, rd, err);
        expect_equal(64'(err), 64'd1, "unmapped read error");
        apb_xfer(1'b1, `TRACE_ADDR_DROPS, 32'd5, rd, err);
        expect_equal(64'(err), 64'd1, "DROPS write error");
        apb_xfer(1'b0, 12'h180, 32'd0, rd, err);
        expect_equal(64'(err), 64'd1, "read past log error");
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_tag   = '0;
        pc_stall    = 1'b0;
        if_id_stall = 1'b0;
        if_flush    = 1'b0;
        apb_req     = '0;
        lfsr        = 32'hd1b7;
        next_tag    = `TRACE_TAG_W'(1);
        errors      = 0;
        checks      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_stream(8, 0);
        check_log();
        run_stream(12, 1);
        check_log();
        run_stream(12, 2);
        check_log();
        run_stream(40, 0);
        check_overfill();
        afails = dut.u_tracker.trk_checks.fails + dut.top_checks.fails;
        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/pipe_trace_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module pipe_trace_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      pc_stall,
    input logic                      if_flush,
    input logic                      fetch_ready,
    input logic                      rec_push,
    input logic [`TRACE_CYCLE_W-1:0] lat,
    input logic [`TRACE_HELD_W-1:0]  held
);

    int fails = 0;

    // Fetch is blocked whenever IF is frozen or flushed
    assert property (@(posedge clk) disable iff (rst) (pc_stall || if_flush) |-> !fetch_ready)
        else begin
            fails++;
            $error("fetch_ready high during pc_stall or if_flush");
        end

    // Retire latency is four stages plus holds
    assert property (@(posedge clk) disable iff (rst)
        rec_push |-> (lat == `TRACE_CYCLE_W'(4) + `TRACE_CYCLE_W'(held)))
        else begin
            fails++;
            $error("retire record latency does not match held count");
        end

endmodule

`default_nettype wire

//--- rtl/pipe_trace_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module pipe_trace_top
    import trace_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_valid,
    input  logic [`TRACE_TAG_W-1:0] fetch_tag,
    input  logic                    pc_stall,
    input  logic                    if_id_stall,
    input  logic                    if_flush,
    input  apb_req_t                apb_req,
    output logic                    fetch_ready,
    output apb_rsp_t                apb_rsp
);

    logic [`TRACE_CYCLE_W-1:0] cycle;
    retire_rec_t               ret_rec;
    logic                      ret_push;
    retire_rec_t               ret_dout;
    logic                      ret_valid;
    logic                      ret_pop;
    logic                      ret_ovf;
    stall_rec_t                stl_rec;
    logic                      stl_push;
    stall_rec_t                stl_dout;
    logic                      stl_valid;
    logic                      stl_pop;
    logic                      stl_ovf;
    logic                      wr_valid;
    trace_entry_t              wr_entry;

    pipe_stage_tracker u_tracker (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_tag   (fetch_tag),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush),
        .fetch_ready (fetch_ready),
        .cycle       (cycle),
        .rec         (ret_rec),
        .rec_push    (ret_push)
    );

    stall_event_logger u_logger (
        .clk         (clk),
        .rst         (rst),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush),
        .cycle       (cycle),
        .rec         (stl_rec),
        .rec_push    (stl_push)
    );

    rec_fifo #(.T(retire_rec_t)) ret_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (ret_push),
        .din      (ret_rec),
        .pop      (ret_pop),
        .dout     (ret_dout),
        .valid    (ret_valid),
        .overflow (ret_ovf)
    );

    rec_fifo #(.T(stall_rec_t)) stl_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (stl_push),
        .din      (stl_rec),
        .pop      (stl_pop),
        .dout     (stl_dout),
        .valid    (stl_valid),
        .overflow (stl_ovf)
    );

    trace_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .ret_valid (ret_valid),
        .ret_data  (ret_dout),
        .stl_valid (stl_valid),
        .stl_data  (stl_dout),
        .ret_pop   (ret_pop),
        .stl_pop   (stl_pop),
        .wr_valid  (wr_valid),
        .wr_entry  (wr_entry)
    );

    trace_apb_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .wr_valid      (wr_valid),
        .wr_entry      (wr_entry),
        .cycle         (cycle),
        .fifo_overflow ({stl_ovf, ret_ovf}),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp)
    );

endmodule

`default_nettype wire

//--- rtl/trace_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module trace_apb_regs
    import trace_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_valid,
    input  trace_entry_t              wr_entry,
    input  logic [`TRACE_CYCLE_W-1:0] cycle,
    input  logic [1:0]                fifo_overflow,
    input  apb_req_t                  apb_req,
    output apb_rsp_t                  apb_rsp
);

    localparam int DEPTH = `TRACE_RAM_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int LOG_BYTES = DEPTH * 8;

    trace_entry_t             mem [DEPTH];
    logic [IDX_W:0]           count;
    logic [15:0]              ram_drops;
    logic [15:0]              fifo_drops;
    logic                     full;
    logic                     access;
    logic                     clear;
    logic [`TRACE_APB_AW-1:0] log_off;
    logic                     in_log;
    trace_entry_t             rd_entry;

    assign full   = (count == (IDX_W + 1)'(DEPTH));
    assign access = apb_req.psel && apb_req.penable;
    assign clear  = access && apb_req.pwrite && (apb_req.paddr == `TRACE_ADDR_STATUS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count      <= '0;
            ram_drops  <= '0;
            fifo_drops <= '0;
        end else if (clear) begin
            count      <= '0;
            ram_drops  <= '0;
            fifo_drops <= '0;
        end else begin
            if (wr_valid && !full) count <= count + (IDX_W + 1)'(1);
            if (wr_valid && full) ram_drops <= ram_drops + 16'd1;
            fifo_drops <= fifo_drops + 16'(fifo_overflow[0]) + 16'(fifo_overflow[1]);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && !full) mem[count[IDX_W-1:0]] <= wr_entry;
    end

    // Two words per entry above the log base
    assign log_off  = apb_req.paddr - `TRACE_ADDR_LOG_BASE;
    assign in_log   = (apb_req.paddr >= `TRACE_ADDR_LOG_BASE)
                   && (log_off < `TRACE_APB_AW'(LOG_BYTES))
                   && (apb_req.paddr[1:0] == 2'b00);
    assign rd_entry = mem[log_off[IDX_W+2:3]];

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
        if (apb_req.pwrite) begin
            apb_rsp.pslverr = access && (apb_req.paddr != `TRACE_ADDR_STATUS);
        end else if (apb_req.paddr == `TRACE_ADDR_STATUS) begin
            apb_rsp.prdata[IDX_W:0] = count;
            apb_rsp.prdata[31]      = full;
        end else if (apb_req.paddr == `TRACE_ADDR_DROPS) begin
            apb_rsp.prdata = {fifo_drops, ram_drops};
        end else if (apb_req.paddr == `TRACE_ADDR_CYCLE) begin
            apb_rsp.prdata[`TRACE_CYCLE_W-1:0] = cycle;
        end else if (in_log) begin
            if (log_off[2]) begin
                apb_rsp.prdata[31]   = rd_entry.src;
                apb_rsp.prdata[15:0] = rd_entry.body[47:32];
            end else begin
                apb_rsp.prdata = rd_entry.body[31:0];
            end
        end else begin
            apb_rsp.pslverr = access;
        end
    end

endmodule

`default_nettype wire

//--- rtl/trace_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module trace_arbiter
    import trace_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         ret_valid,
    input  retire_rec_t  ret_data,
    input  logic         stl_valid,
    input  stall_rec_t   stl_data,
    output logic         ret_pop,
    output logic         stl_pop,
    output logic         wr_valid,
    output trace_entry_t wr_entry
);

    // Low means retire has priority on a tie
    logic prefer_stl;

    assign ret_pop = ret_valid && (!stl_valid || !prefer_stl);
    assign stl_pop = stl_valid && !ret_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_valid   <= 1'b0;
            prefer_stl <= 1'b0;
        end else begin
            wr_valid <= ret_pop || stl_pop;
            if (ret_pop) begin
                prefer_stl <= 1'b1;
            end else if (stl_pop) begin
                prefer_stl <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ret_pop) begin
            wr_entry <= '{src: SRC_RETIRE, rsvd: '0, body: ret_data};
        end else if (stl_pop) begin
            wr_entry <= '{src: SRC_STALL, rsvd: '0, body: stl_data};
        end
    end

endmodule

`default_nettype wire

//--- rtl/rec_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module rec_fifo #(
    parameter type T = logic [47:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic valid,
    output logic overflow
);

    localparam int DEPTH = `TRACE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == (PTR_W + 1)'(DEPTH));
    assign valid    = (count != '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && valid;
    assign overflow = push && full;
    assign dout     = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + PTR_W'(1);
            if (do_pop) rd_ptr <= rd_ptr + PTR_W'(1);
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

endmodule

`default_nettype wire

//--- rtl/stall_event_logger.sv
`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module stall_event_logger
    import trace_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pc_stall,
    input  logic                      if_id_stall,
    input  logic                      if_flush,
    input  logic [`TRACE_CYCLE_W-1:0] cycle,
    output stall_rec_t                rec,
    output logic                      rec_push
);

    logic                      run_open;
    logic [`TRACE_CYCLE_W-1:0] run_start;
    logic [`TRACE_CYCLE_W-1:0] run_len;
    stall_kind_t               run_kind;
    stall_kind_t               cur_kind;
    logic                      event_now;

    assign cur_kind.pc    = pc_stall;
    assign cur_kind.ifid  = if_id_stall;
    assign cur_kind.flush = if_flush;
    assign event_now      = pc_stall || if_id_stall || if_flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_open <= 1'b0;
        end else begin
            run_open <= event_now;
        end
    end

    always_ff @(posedge clk) begin
        if (event_now) begin
            if (!run_open) begin
                run_start <= cycle;
                run_len   <= `TRACE_CYCLE_W'(1);
                run_kind  <= cur_kind;
            end else begin
                run_len  <= run_len + `TRACE_CYCLE_W'(1);
                run_kind <= run_kind | cur_kind;
            end
        end
    end

    // First quiet cycle closes the run
    assign rec_push        = run_open && !event_now;
    assign rec.pad         = '0;
    assign rec.kind        = run_kind;
    assign rec.start_cycle = run_start;
    assign rec.length      = run_len;

endmodule

`default_nettype wire

//--- rtl/pipe_stage_tracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module pipe_stage_tracker
    import trace_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_valid,
    input  logic [`TRACE_TAG_W-1:0]   fetch_tag,
    input  logic                      pc_stall,
    input  logic                      if_id_stall,
    input  logic                      if_flush,
    output logic                      fetch_ready,
    output logic [`TRACE_CYCLE_W-1:0] cycle,
    output retire_rec_t               rec,
    output logic                      rec_push
);

    localparam int S_IF  = 0;
    localparam int S_ID  = 1;
    localparam int S_EX  = 2;
    localparam int S_MEM = 3;
    localparam int S_WB  = 4;

    typedef struct packed {
        logic [`TRACE_TAG_W-1:0]   tag;
        logic [`TRACE_CYCLE_W-1:0] fetch_cycle;
        logic [`TRACE_HELD_W-1:0]  held;
    } slot_t;

    logic [4:0] vld_q;
    logic [4:0] vld_d;
    slot_t      slot_q [5];
    slot_t      slot_d [5];
    logic       adv_id;
    logic       adv_if;
    logic       accept;

    function automatic logic [`TRACE_HELD_W-1:0] sat_inc(input logic [`TRACE_HELD_W-1:0] v);
        return (&v) ? v : v + `TRACE_HELD_W'(1);
    endfunction

    assign adv_id      = !if_id_stall;
    assign adv_if      = !pc_stall && (!vld_q[S_ID] || adv_id);
    assign fetch_ready = !pc_stall && !if_flush && (!vld_q[S_IF] || adv_if);
    assign accept      = fetch_valid && fetch_ready;

    always_comb begin
        vld_d  = vld_q;
        slot_d = slot_q;

        // Back end never stalls
        vld_d[S_WB]   = vld_q[S_MEM];
        slot_d[S_WB]  = slot_q[S_MEM];
        vld_d[S_MEM]  = vld_q[S_EX];
        slot_d[S_MEM] = slot_q[S_EX];

        if (if_flush) begin
            vld_d[S_EX] = 1'b0;
            vld_d[S_ID] = 1'b0;
            vld_d[S_IF] = 1'b0;
        end else begin
            // Bubble into EX when ID holds
            vld_d[S_EX]  = adv_id && vld_q[S_ID];
            slot_d[S_EX] = slot_q[S_ID];

            if (adv_if) begin
                vld_d[S_ID]  = vld_q[S_IF];
                slot_d[S_ID] = slot_q[S_IF];
            end else if (adv_id) begin
                vld_d[S_ID] = 1'b0;
            end else begin
                slot_d[S_ID].held = sat_inc(slot_q[S_ID].held);
            end

            if (accept) begin
                vld_d[S_IF]  = 1'b1;
                slot_d[S_IF] = '{tag: fetch_tag,
                                 fetch_cycle: cycle + `TRACE_CYCLE_W'(1),
                                 held: '0};
            end else if (adv_if) begin
                vld_d[S_IF] = 1'b0;
            end else begin
                slot_d[S_IF].held = sat_inc(slot_q[S_IF].held);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
            cycle <= '0;
        end else begin
            vld_q <= vld_d;
            cycle <= cycle + `TRACE_CYCLE_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        slot_q <= slot_d;
    end

    // Record taken from WB, captured by the FIFO at the edge ending WB
    assign rec_push         = vld_q[S_WB];
    assign rec.tag          = slot_q[S_WB].tag;
    assign rec.fetch_cycle  = slot_q[S_WB].fetch_cycle;
    assign rec.retire_cycle = cycle;
    assign rec.held         = slot_q[S_WB].held;

endmodule

`default_nettype wire

//--- rtl/trace_pkg.sv
`default_nettype none

`include "trace_settings.svh"

package trace_pkg;

    localparam int REC_W = 48;
    localparam int STALL_PAD_W = REC_W - 3 - 2 * `TRACE_CYCLE_W;

    typedef struct packed {
        logic [`TRACE_TAG_W-1:0]   tag;
        logic [`TRACE_CYCLE_W-1:0] fetch_cycle;
        logic [`TRACE_CYCLE_W-1:0] retire_cycle;
        logic [`TRACE_HELD_W-1:0]  held;
    } retire_rec_t;

    typedef struct packed {
        logic pc;
        logic ifid;
        logic flush;
    } stall_kind_t;

    // Padding sits on top so the body stays 48 bits
    typedef struct packed {
        logic [STALL_PAD_W-1:0]    pad;
        stall_kind_t               kind;
        logic [`TRACE_CYCLE_W-1:0] start_cycle;
        logic [`TRACE_CYCLE_W-1:0] length;
    } stall_rec_t;

    typedef enum logic {
        SRC_RETIRE = 1'b0,
        SRC_STALL  = 1'b1
    } trace_src_e;

    typedef struct packed {
        trace_src_e       src;
        logic [14:0]      rsvd;
        logic [REC_W-1:0] body;
    } trace_entry_t;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [`TRACE_APB_AW-1:0] paddr;
        logic [31:0]              pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- include/trace_settings.svh
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// Counter and record field widths
`define TRACE_CYCLE_W        16
`define TRACE_TAG_W          8
`define TRACE_HELD_W         8

`define TRACE_FIFO_DEPTH     4
`define TRACE_RAM_DEPTH      32

// APB register map
`define TRACE_APB_AW         12
`define TRACE_ADDR_STATUS    12'h000
`define TRACE_ADDR_DROPS     12'h004
`define TRACE_ADDR_CYCLE     12'h008
`define TRACE_ADDR_LOG_BASE  12'h080

`endif
